//--- src/op_pkg.sv
// operation definitions for the integer execute cluster
// datapath width, alu opcodes and branch compare kinds

package op_pkg;

	// operand and result width
	localparam int XLEN = 32;

	// opcodes shared by both functional units
	typedef enum logic [2:0] {
		OP_ADD = 3'd0,
		OP_SUB = 3'd1,
		OP_AND = 3'd2,
		OP_OR  = 3'd3,
		OP_XOR = 3'd4
	} alu_op_t;

	// add/sub unit handles OP_ADD and OP_SUB
	// logic unit handles OP_AND, OP_OR and OP_XOR

	// branch compare kinds
	typedef enum logic [1:0] {
		BR_NONE = 2'b00, // plain arithmetic
		BR_NE   = 2'b01, // taken when rs1 != rs2
		BR_EQ   = 2'b10, // taken when rs1 == rs2
		BR_LT   = 2'b11  // signed rs1 < rs2
	} br_type_t;

	// any branch forces a subtract in the add/sub unit

endpackage

//--- src/cdb_pkg.sv
// common data bus definitions
// rob tag width and the source ids the cdb arbiter grants between

package cdb_pkg;

	// reorder buffer entry index
	localparam int ROB_TAG_W = 4;

	// units that can drive the cdb
	typedef enum logic {
		SRC_ADD   = 1'b0,
		SRC_LOGIC = 1'b1
	} cdb_src_t;

	// arbiter remembers the last winner as a cdb_src_t
	// reset value SRC_LOGIC hands the first tie to the add/sub unit

endpackage

//--- src/ripple_adder.sv
// ripple carry adder/subtractor
// subtracts by inverting b with carry in set, reports zero, negative and overflow

`timescale 1ns/1ps

module ripple_adder
	import op_pkg::*;
(
	input  logic [XLEN-1:0] a,
	input  logic [XLEN-1:0] b,
	input  logic            sub,
	output logic [XLEN-1:0] sum,
	output logic            zero,
	output logic            negative,
	output logic            overflow
);

	logic [XLEN-1:0] b_eff;
	logic [XLEN:0]   carry;
	logic [XLEN-1:0] half; // a xor b per bit

	assign b_eff    = sub ? ~b : b;
	assign carry[0] = sub; // +1 completes two's complement

	genvar i;
	generate
		for (i = 0; i < XLEN; i++) begin : g_fa
			assign half[i]    = a[i] ^ b_eff[i];
			assign sum[i]     = half[i] ^ carry[i];
			assign carry[i+1] = (a[i] & b_eff[i]) | (half[i] & carry[i]);
		end
	endgenerate

	// signed overflow when carry into and out of the msb differ
	assign overflow = carry[XLEN] ^ carry[XLEN-1];
	assign zero     = ~|sum;
	assign negative = sum[XLEN-1];

endmodule

//--- src/add_sub_unit.sv
// add/sub functional unit
// adds or subtracts rs1 and rs2, resolves BNE/BEQ/BLT
// and holds the tagged result until the cdb takes it

`timescale 1ns/1ps

module add_sub_unit
	import op_pkg::*;
	import cdb_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 valid,
	input  logic                 yumi,
	input  alu_op_t              op,
	input  br_type_t             br_type,
	input  logic [ROB_TAG_W-1:0] rob_tag,
	input  logic [XLEN-1:0]      rs1,
	input  logic [XLEN-1:0]      rs2,
	output logic                 ready,
	output logic                 done,
	output logic [ROB_TAG_W-1:0] rob_out,
	output logic [XLEN-1:0]      result,
	output logic                 branch_taken
);

	logic            sub;
	logic [XLEN-1:0] sum;
	logic            zero;
	logic            negative;
	logic            overflow;
	logic            taken;
	logic            accept;

	// branches compare by subtraction
	assign sub = (op == OP_SUB) || (br_type != BR_NONE);

	ripple_adder adder_i (
		.a        (rs1),
		.b        (rs2),
		.sub      (sub),
		.sum      (sum),
		.zero     (zero),
		.negative (negative),
		.overflow (overflow)
	);

	always_comb begin
		case (br_type)
			BR_NE:   taken = !zero;
			BR_EQ:   taken = zero;
			BR_LT:   taken = negative ^ overflow; // signed less than
			default: taken = 1'b0;
		endcase
	end

	assign ready  = !done;
	assign accept = valid && ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			done <= 1'b0;
		end else if (accept) begin
			done <= 1'b1;
		end else if (yumi) begin
			done <= 1'b0; // free again next cycle
		end
	end

	// captured on issue, stable while done
	always_ff @(posedge clk) begin
		if (accept) begin
			result       <= sum;
			branch_taken <= taken;
			rob_out      <= rob_tag;
		end
	end

	// issuer has to wait for ready
	a_issue_when_ready: assert property (
		@(posedge clk) disable iff (!rst_n) valid |-> ready
	);

	// the arbiter only grants a finished unit
	a_yumi_needs_done: assert property (
		@(posedge clk) disable iff (!rst_n) yumi |-> done
	);

endmodule

//--- src/logic_unit.sv
// logic functional unit
// AND/OR/XOR of rs1 and rs2, result held with its rob tag until taken

`timescale 1ns/1ps

module logic_unit
	import op_pkg::*;
	import cdb_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 valid,
	input  logic                 yumi,
	input  alu_op_t              op,
	input  logic [ROB_TAG_W-1:0] rob_tag,
	input  logic [XLEN-1:0]      rs1,
	input  logic [XLEN-1:0]      rs2,
	output logic                 ready,
	output logic                 done,
	output logic [ROB_TAG_W-1:0] rob_out,
	output logic [XLEN-1:0]      result
);

	logic [XLEN-1:0] logic_res;
	logic            accept;

	always_comb begin
		case (op)
			OP_OR:   logic_res = rs1 | rs2;
			OP_XOR:  logic_res = rs1 ^ rs2;
			default: logic_res = rs1 & rs2; // OP_AND
		endcase
	end

	assign ready  = !done;
	assign accept = valid && ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			done <= 1'b0;
		end else if (accept) begin
			done <= 1'b1;
		end else if (yumi) begin
			done <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			result  <= logic_res;
			rob_out <= rob_tag;
		end
	end

	a_issue_when_ready: assert property (
		@(posedge clk) disable iff (!rst_n) valid |-> ready
	);

	// add/sub opcodes belong to the other unit
	a_logic_op_only: assert property (
		@(posedge clk) disable iff (!rst_n)
		valid |-> (op inside {OP_AND, OP_OR, OP_XOR})
	);

endmodule

//--- src/cdb_arbiter.sv
// cdb arbiter
// grants the bus to one finished unit per cycle, round robin on ties,
// and muxes the winner's tag, result and branch bit onto the cdb

`timescale 1ns/1ps

module cdb_arbiter
	import op_pkg::*;
	import cdb_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 add_done,
	input  logic [ROB_TAG_W-1:0] add_rob,
	input  logic [XLEN-1:0]      add_result,
	input  logic                 add_taken,
	input  logic                 logic_done,
	input  logic [ROB_TAG_W-1:0] logic_rob,
	input  logic [XLEN-1:0]      logic_result,
	output logic                 add_yumi,
	output logic                 logic_yumi,
	output logic                 cdb_valid,
	output logic [ROB_TAG_W-1:0] cdb_rob,
	output logic [XLEN-1:0]      cdb_result,
	output logic                 cdb_branch_taken
);

	cdb_src_t last_win;
	cdb_src_t winner;

	// on a tie the unit that lost last time goes first
	assign add_yumi   = add_done && (!logic_done || last_win == SRC_LOGIC);
	assign logic_yumi = logic_done && (!add_done || last_win == SRC_ADD);
	assign cdb_valid  = add_yumi || logic_yumi;
	assign winner     = logic_yumi ? SRC_LOGIC : SRC_ADD;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			last_win <= SRC_LOGIC; // add wins the first tie
		end else if (cdb_valid) begin
			last_win <= winner;
		end
	end

	always_comb begin
		case (winner)
			SRC_LOGIC: begin
				cdb_rob          = logic_rob;
				cdb_result       = logic_result;
				cdb_branch_taken = 1'b0; // logic ops never branch
			end
			default: begin
				cdb_rob          = add_rob;
				cdb_result       = add_result;
				cdb_branch_taken = add_taken && add_yumi;
			end
		endcase
	end

	a_one_grant: assert property (
		@(posedge clk) disable iff (!rst_n) !(add_yumi && logic_yumi)
	);

endmodule

//--- src/exec_cluster.sv
// integer execute cluster
// add/sub and logic units sharing one common data bus through a round robin arbiter

`timescale 1ns/1ps

module exec_cluster
	import op_pkg::*;
	import cdb_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 add_valid,
	input  logic                 logic_valid,
	input  alu_op_t              op,
	input  br_type_t             br_type,
	input  logic [ROB_TAG_W-1:0] rob_tag,
	input  logic [XLEN-1:0]      rs1,
	input  logic [XLEN-1:0]      rs2,
	output logic                 add_ready,
	output logic                 logic_ready,
	output logic                 cdb_valid,
	output logic [ROB_TAG_W-1:0] cdb_rob,
	output logic [XLEN-1:0]      cdb_result,
	output logic                 cdb_branch_taken
);

	logic                 add_done;
	logic                 add_yumi;
	logic [ROB_TAG_W-1:0] add_rob;
	logic [XLEN-1:0]      add_result;
	logic                 add_taken;
	logic                 logic_done;
	logic                 logic_yumi;
	logic [ROB_TAG_W-1:0] logic_rob;
	logic [XLEN-1:0]      logic_result;

	add_sub_unit add_sub_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.valid        (add_valid),
		.yumi         (add_yumi),
		.op           (op),
		.br_type      (br_type),
		.rob_tag      (rob_tag),
		.rs1          (rs1),
		.rs2          (rs2),
		.ready        (add_ready),
		.done         (add_done),
		.rob_out      (add_rob),
		.result       (add_result),
		.branch_taken (add_taken)
	);

	logic_unit logic_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.valid   (logic_valid),
		.yumi    (logic_yumi),
		.op      (op),
		.rob_tag (rob_tag),
		.rs1     (rs1),
		.rs2     (rs2),
		.ready   (logic_ready),
		.done    (logic_done),
		.rob_out (logic_rob),
		.result  (logic_result)
	);

	cdb_arbiter arb_i (
		.clk              (clk),
		.rst_n            (rst_n),
		.add_done         (add_done),
		.add_rob          (add_rob),
		.add_result       (add_result),
		.add_taken        (add_taken),
		.logic_done       (logic_done),
		.logic_rob        (logic_rob),
		.logic_result     (logic_result),
		.add_yumi         (add_yumi),
		.logic_yumi       (logic_yumi),
		.cdb_valid        (cdb_valid),
		.cdb_rob          (cdb_rob),
		.cdb_result       (cdb_result),
		.cdb_branch_taken (cdb_branch_taken)
	);

endmodule

//--- bench/exec_cluster_tb.sv
// testbench for the integer execute cluster
// table driven issue, cdb scoreboard matched on rob tag, tie order and ready checks

`timescale 1ns/1ps

module exec_cluster_tb
	import op_pkg::*;
	import cdb_pkg::*;
();

	localparam int MAX_ROWS = 64;
	localparam int N_RANDOM = 12;

	logic                 clk;
	logic                 rst_n;
	logic                 add_valid;
	logic                 logic_valid;
	alu_op_t              op;
	br_type_t             br_type;
	logic [ROB_TAG_W-1:0] rob_tag;
	logic [XLEN-1:0]      rs1;
	logic [XLEN-1:0]      rs2;
	logic                 add_ready;
	logic                 logic_ready;
	logic                 cdb_valid;
	logic [ROB_TAG_W-1:0] cdb_rob;
	logic [XLEN-1:0]      cdb_result;
	logic                 cdb_branch_taken;

	cdb_src_t             row_unit [MAX_ROWS];
	alu_op_t              row_op [MAX_ROWS];
	br_type_t             row_br [MAX_ROWS];
	logic [ROB_TAG_W-1:0] row_tag [MAX_ROWS];
	logic [XLEN-1:0]      row_rs1 [MAX_ROWS];
	logic [XLEN-1:0]      row_rs2 [MAX_ROWS];
	logic [XLEN-1:0]      row_res [MAX_ROWS];
	logic                 row_taken [MAX_ROWS];
	logic                 row_pair [MAX_ROWS]; // issued in the same cycle as the row before
	int                   row_issue [MAX_ROWS];
	int                   row_lat [MAX_ROWS];
	int                   n_rows;

	int       pending [$]; // rows issued but not yet on the cdb
	int       cycles;
	int       cycle_limit;
	integer   seed;
	cdb_src_t last_src; // last unit granted the bus

	exec_cluster exec_cluster_i (
		.clk              (clk),
		.rst_n            (rst_n),
		.add_valid        (add_valid),
		.logic_valid      (logic_valid),
		.op               (op),
		.br_type          (br_type),
		.rob_tag          (rob_tag),
		.rs1              (rs1),
		.rs2              (rs2),
		.add_ready        (add_ready),
		.logic_ready      (logic_ready),
		.cdb_valid        (cdb_valid),
		.cdb_rob          (cdb_rob),
		.cdb_result       (cdb_result),
		.cdb_branch_taken (cdb_branch_taken)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic abort_run();
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic fail_run(input string why);
		$display("ERROR: %s", why);
		abort_run();
	endtask

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic add_row(input cdb_src_t unit, input alu_op_t o, input br_type_t br,
		input logic [ROB_TAG_W-1:0] tag, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
		input logic [XLEN-1:0] res, input logic taken, input logic pair);
		row_unit[n_rows]  = unit;
		row_op[n_rows]    = o;
		row_br[n_rows]    = br;
		row_tag[n_rows]   = tag;
		row_rs1[n_rows]   = a;
		row_rs2[n_rows]   = b;
		row_res[n_rows]   = res;
		row_taken[n_rows] = taken;
		row_pair[n_rows]  = pair;
		n_rows++;
	endtask

	// reference behavior of both units
	task automatic predict(input cdb_src_t unit, input alu_op_t o, input br_type_t br,
		input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
		output logic [XLEN-1:0] res, output logic taken);
		taken = 1'b0;
		if (unit == SRC_LOGIC) begin
			case (o)
				OP_OR:   res = a | b;
				OP_XOR:  res = a ^ b;
				default: res = a & b;
			endcase
		end else begin
			res = (o == OP_SUB || br != BR_NONE) ? a - b : a + b;
			case (br)
				BR_NE:   taken = (a != b);
				BR_EQ:   taken = (a == b);
				BR_LT:   taken = ($signed(a) < $signed(b));
				default: taken = 1'b0;
			endcase
		end
	endtask

	task automatic add_random_rows();
		integer          r;
		int              k;
		cdb_src_t        unit;
		alu_op_t         o;
		br_type_t        br;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] res;
		logic            taken;
		for (k = 0; k < N_RANDOM; k++) begin
			r    = $random(seed);
			unit = cdb_src_t'(r[0]);
			a    = $random(seed);
			b    = (r[3:2] == 2'b00) ? a : $random(seed); // equal operands now and then
			br   = BR_NONE;
			if (unit == SRC_ADD) begin
				o  = r[1] ? OP_SUB : OP_ADD;
				br = br_type_t'(r[5:4]);
			end else begin
				o = (r[5:4] == 2'b00) ? OP_AND : ((r[5:4] == 2'b01) ? OP_OR : OP_XOR);
			end
			predict(unit, o, br, a, b, res, taken);
			add_row(unit, o, br, n_rows[ROB_TAG_W-1:0], a, b, res, taken, 1'b0);
		end
	endtask

	task automatic build_table();
		n_rows = 0;
		add_row(SRC_ADD, OP_ADD, BR_NONE, 4'd1, 32'd5, 32'd7, 32'h0000000C, 1'b0, 1'b0);
		add_row(SRC_ADD, OP_ADD, BR_NONE, 4'd2, 32'h7FFFFFFF, 32'd1, 32'h80000000, 1'b0, 1'b0);
		add_row(SRC_ADD, OP_SUB, BR_NONE, 4'd3, 32'h80000000, 32'd1, 32'h7FFFFFFF, 1'b0, 1'b0);
		add_row(SRC_ADD, OP_SUB, BR_NONE, 4'd4, 32'd3, 32'd5, 32'hFFFFFFFE, 1'b0, 1'b0);
		add_row(SRC_ADD, OP_ADD, BR_NONE, 4'd5, 32'hFFFFFFFF, 32'd1, 32'h00000000, 1'b0, 1'b0);
		// branches subtract whatever op says
		add_row(SRC_ADD, OP_ADD, BR_NE, 4'd6, 32'd10, 32'd10, 32'h00000000, 1'b0, 1'b0);
		add_row(SRC_ADD, OP_ADD, BR_NE, 4'd7, 32'd10, 32'd3, 32'h00000007, 1'b1, 1'b0);
		add_row(SRC_ADD, OP_ADD, BR_EQ, 4'd8, 32'h1234, 32'h1234, 32'h00000000, 1'b1, 1'b0);
		add_row(SRC_ADD, OP_SUB, BR_EQ, 4'd9, 32'd1, 32'd2, 32'hFFFFFFFF, 1'b0, 1'b0);
		add_row(SRC_ADD, OP_SUB, BR_LT, 4'd10, 32'hFFFFFFFF, 32'd1, 32'hFFFFFFFE, 1'b1, 1'b0);
		add_row(SRC_ADD, OP_SUB, BR_LT, 4'd11, 32'd1, 32'hFFFFFFFF, 32'h00000002, 1'b0, 1'b0);
		add_row(SRC_ADD, OP_ADD, BR_LT, 4'd12, 32'h80000000, 32'h7FFFFFFF, 32'h1, 1'b1, 1'b0);
		add_row(SRC_ADD, OP_ADD, BR_LT, 4'd13, 32'h7FFFFFFF, 32'h80000000, 32'hFFFFFFFF, 1'b0, 1'b0);
		add_row(SRC_LOGIC, OP_AND, BR_NONE, 4'd14, 32'hF0F01234, 32'h0FF0FFFF, 32'h00F01234, 1'b0, 1'b0);
		add_row(SRC_LOGIC, OP_OR, BR_NONE, 4'd15, 32'hF0000001, 32'h000000F0, 32'hF00000F1, 1'b0, 1'b0);
		add_row(SRC_LOGIC, OP_XOR, BR_NONE, 4'd0, 32'hAAAA5555, 32'hFFFF0000, 32'h55555555, 1'b0, 1'b0);
		// both units finish together, shared operand bus so same tag
		add_row(SRC_ADD, OP_OR, BR_NE, 4'd1, 32'hFF, 32'h0F, 32'h000000F0, 1'b1, 1'b0);
		add_row(SRC_LOGIC, OP_OR, BR_NONE, 4'd1, 32'hFF, 32'h0F, 32'h000000FF, 1'b0, 1'b1);
		add_row(SRC_ADD, OP_ADD, BR_NONE, 4'd2, 32'h100, 32'h23, 32'h00000123, 1'b0, 1'b0);
		add_row(SRC_ADD, OP_AND, BR_LT, 4'd3, 32'hFFFFFFF0, 32'h10, 32'hFFFFFFE0, 1'b1, 1'b0);
		add_row(SRC_LOGIC, OP_AND, BR_NONE, 4'd3, 32'hFFFFFFF0, 32'h10, 32'h00000010, 1'b0, 1'b1);
		add_random_rows();
	endtask

	// scoreboard, runs once per cycle at the falling edge
	task automatic check_cycle();
		int add_cnt;
		int logic_cnt;
		int hits [$];
		int pos;
		int idx;
		add_cnt   = 0;
		logic_cnt = 0;
		foreach (pending[k]) begin
			if (row_unit[pending[k]] == SRC_ADD) add_cnt++;
			else logic_cnt++;
		end
		compare("add_ready", 32'(add_ready), 32'(add_cnt == 0));
		compare("logic_ready", 32'(logic_ready), 32'(logic_cnt == 0));
		if (cdb_valid) begin
			foreach (pending[k]) begin
				if (row_tag[pending[k]] == cdb_rob) hits.push_back(k);
			end
			if (hits.size() == 0) begin
				fail_run($sformatf("cdb carried rob tag 0x%h that no issued entry expects", cdb_rob));
			end else begin
				pos = hits[0];
				if (hits.size() > 1) begin // tie goes to the unit that lost last time
					if (row_unit[pending[pos]] == last_src) begin
						pos = hits[1];
						row_lat[pending[hits[0]]] = 2;
					end else begin
						row_lat[pending[hits[1]]] = 2;
					end
				end
				idx = pending[pos];
				compare("cdb_result", cdb_result, row_res[idx]);
				compare("cdb_branch_taken", 32'(cdb_branch_taken), 32'(row_taken[idx]));
				compare("cdb latency", cycles - row_issue[idx], row_lat[idx]);
				pending.delete(pos);
				last_src = row_unit[idx];
			end
		end
	endtask

	task automatic tick();
		@(negedge clk);
		cycles++;
		if (cycles > cycle_limit) begin
			fail_run($sformatf("timeout after %0d cycles, %0d entries still outstanding",
				cycles, pending.size()));
		end else begin
			check_cycle();
		end
	endtask

	function automatic logic target_ready(input int i, input logic both);
		if (both) return add_ready && logic_ready;
		return (row_unit[i] == SRC_ADD) ? add_ready : logic_ready;
	endfunction

	initial begin
		int   i;
		logic both;
		rst_n       = 1'b0;
		add_valid   = 1'b0;
		logic_valid = 1'b0;
		op          = OP_ADD;
		br_type     = BR_NONE;
		rob_tag     = '0;
		rs1         = '0;
		rs2         = '0;
		seed        = 40;
		cycles      = 0;
		last_src    = SRC_LOGIC;
		build_table();
		cycle_limit = n_rows * 8 + 50;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		compare("add_ready", 32'(add_ready), 32'd1);
		compare("logic_ready", 32'(logic_ready), 32'd1);
		compare("cdb_valid", 32'(cdb_valid), 32'd0);
		i = 0;
		while (i < n_rows) begin
			both = (i + 1 < n_rows) && row_pair[i + 1];
			while (!target_ready(i, both)) tick();
			op           = row_op[i];
			br_type      = row_br[i];
			rob_tag      = row_tag[i];
			rs1          = row_rs1[i];
			rs2          = row_rs2[i];
			add_valid    = both || row_unit[i] == SRC_ADD;
			logic_valid  = both || row_unit[i] == SRC_LOGIC;
			row_issue[i] = cycles;
			row_lat[i]   = 1;
			pending.push_back(i);
			if (both) begin
				row_issue[i + 1] = cycles;
				row_lat[i + 1]   = 1;
				pending.push_back(i + 1);
			end
			tick();
			add_valid   = 1'b0;
			logic_valid = 1'b0;
			i = both ? i + 2 : i + 1;
		end
		while (pending.size() != 0) tick();
		tick(); // bus must stay idle once drained
		$display("=== PASS ===");
		$finish;
	end

endmodule

//--- all.f
src/op_pkg.sv
src/cdb_pkg.sv
src/ripple_adder.sv
src/add_sub_unit.sv
src/logic_unit.sv
src/cdb_arbiter.sv
src/exec_cluster.sv
bench/exec_cluster_tb.sv

//--- run.sh
#!/bin/sh
# build and run the execute cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f all.f \
	--top-module exec_cluster_tb \
	--Mdir obj_dir \
	-o exec_cluster_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/exec_cluster_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# the testbench prints the pass line only when every check held
if echo "$out" | grep -qx "=== PASS ==="; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1
